/* mips_cpu.f */
rtl/mips_isa_pkg.sv
rtl/mips_core_pkg.sv
rtl/instr_rom.sv
rtl/pc_counter.sv
rtl/cycle_fsm.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/mips_cpu.sv
tb/clock_gen.sv
tb/mips_cpu_tb.sv

/* tb/mips_cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_tb;

    localparam int words         = mips_core_pkg::test_words;
    localparam int reset_cycles  = 4;
    localparam int quiet_cycles  = 20;
    // lw and sw take 3 cycles, slti and jr take 2
    localparam int program_cycles  = words * 3 + words * 2 + words * 3 + 2;
    localparam int watchdog_cycles = program_cycles + reset_cycles + quiet_cycles + 34;

    logic        clk;
    logic        rst;
    logic        active;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] mem [1024];
    integer      seed;
    int          error_count;
    int          check_count;
    int          load_count;
    int          store_count;
    logic        rst_prev;
    logic        active_prev;
    logic        halt_seen;

    clock_gen u_clock (
        .clk (clk),
        .rst (rst)
    );

    mips_cpu dut (
        .clk            (clk),
        .rst            (rst),
        .active         (active),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // read data follows the address in the same cycle
    assign data_readdata = mem[data_address[11:2]];

    // words near the signed limits and around the compare point
    function automatic logic [31:0] edge_value(input int idx);
        case (idx)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'h7fff_ffff;
            3: return 32'h8000_0000;
            4: return 32'hffff_ffff;
            default: return 32'h0000_0002;
        endcase
    endfunction

    // slti with immediate 1: set when the word is signed below one
    function automatic logic [31:0] expected_slti(input logic [31:0] word);
        return ($signed(word) < 32'sd1) ? 32'd1 : 32'd0;
    endfunction

    task automatic fill_memory();
        int sel;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h5a00_0000 | i;
        end
        // test words, a third of them forced to edge values
        for (int n = 0; n < words; n++) begin
            mem[n] = $random(seed);
            sel = $unsigned($random(seed)) % 9;
            if (sel < 3) begin
                mem[n] = edge_value($unsigned($random(seed)) % 6);
            end
        end
    endtask

    // bus monitor, samples the values of the cycle that just ended
    always @(posedge clk) begin
        check_count++;
        // state is only known once a reset edge has been taken
        if (rst_prev) begin
            assert (active && !data_read && !data_write) else begin
                error_count++;
                $display("error: reset, core not idle and active");
            end
        end else if (halt_seen) begin
            assert (!active && !data_read && !data_write) else begin
                error_count++;
                $display("error: halt, core woke up or strobed after halting");
            end
        end else begin
            if (data_read) begin
                assert (load_count < words && store_count == 0) else begin
                    error_count++;
                    $display("error: load seen after stores or too many loads");
                end
                assert (data_address == mips_core_pkg::load_base + 4 * load_count) else begin
                    error_count++;
                    $display("error: load address expected %h actual %h",
                             mips_core_pkg::load_base + 4 * load_count, data_address);
                end
                load_count++;
            end
            if (data_write) begin
                assert (store_count < words) else begin
                    error_count++;
                    $display("error: more stores than the program holds");
                end
                assert (data_address == mips_core_pkg::store_base + 4 * store_count) else begin
                    error_count++;
                    $display("error: store address expected %h actual %h",
                             mips_core_pkg::store_base + 4 * store_count, data_address);
                end
                assert (data_writedata == expected_slti(mem[store_count % words])) else begin
                    error_count++;
                    $display("error: slti result %0d expected %h actual %h", store_count,
                             expected_slti(mem[store_count % words]), data_writedata);
                end
                store_count++;
            end
            if (active_prev && !active) begin
                halt_seen <= 1'b1;
                assert (store_count == words) else begin
                    error_count++;
                    $display("error: halt expected %0d stores actual %0d", words, store_count);
                end
            end
        end
        rst_prev    <= rst;
        active_prev <= active;
    end

    // ends a run that never halts
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        error_count++;
        $display("error: watchdog, core did not halt within %0d cycles", watchdog_cycles);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed        = 32'hbc27;
        error_count = 0;
        check_count = 0;
        load_count  = 0;
        store_count = 0;
        rst_prev    = 1'b0;
        active_prev = 1'b1;
        halt_seen   = 1'b0;
        fill_memory();
        // run until the core drops active
        do begin
            @(posedge clk);
        end while (rst || active !== 1'b0);
        repeat (quiet_cycles) @(posedge clk);
        // let the monitor finish the last quiet cycle
        @(negedge clk);
        assert (load_count == words && store_count == words) else begin
            error_count++;
            $display("error: totals expected %0d loads and stores actual %0d and %0d",
                     words, load_count, store_count);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period  = 5;
    localparam int reset_cycles = 4;

    // free running 10 ns clock
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset held for the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/mips_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_cpu (
    input  logic        clk,
    input  logic        rst,
    output logic        active,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    mips_core_pkg::ctrl_t ctrl;
    mips_isa_pkg::instr_t ir;
    logic [31:0] pc;
    logic [31:0] instr_readdata;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_result;
    logic [31:0] write_back;
    logic [4:0]  dest_reg;
    logic        halted;

    instr_rom u_rom (
        .instr_address  (pc),
        .instr_readdata (instr_readdata)
    );

    pc_counter u_pc (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .jump_target (rs_data),
        .pc          (pc)
    );

    // fetch is the only state that steps the pc so ir loads with it
    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= mips_isa_pkg::instr_t'(32'd0);
        end else if (ctrl.pc_step) begin
            ir <= mips_isa_pkg::instr_t'(instr_readdata);
        end
    end

    cycle_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .instr   (ir),
        .rs_zero (rs_data == 32'd0),
        .ctrl    (ctrl),
        .halted  (halted)
    );

    // i-type results go to rt and r-type to rd
    assign dest_reg = (ir.opcode == mips_isa_pkg::op_rtype) ? ir.low.r.rd : ir.rt;
    assign write_back = ctrl.reg_src_mem ? data_readdata : alu_result;

    reg_file u_regs (
        .clk        (clk),
        .rst        (rst),
        .rs_addr    (ir.rs),
        .rt_addr    (ir.rt),
        .rd_addr    (dest_reg),
        .write      (ctrl.reg_write),
        .write_data (write_back),
        .rs_data    (rs_data),
        .rt_data    (rt_data)
    );

    alu u_alu (
        .op         (ctrl.alu_op),
        .a          (rs_data),
        .imm        (ir.low.imm),
        .imm_signed (ctrl.imm_signed),
        .result     (alu_result)
    );

    // data bus with plain strobes
    assign data_address   = alu_result;
    assign data_read      = ctrl.data_read;
    assign data_write     = ctrl.data_write;
    assign data_writedata = rt_data;
    assign active         = !halted;

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  mips_core_pkg::alu_op_e            op,
    input  logic [mips_isa_pkg::word_w-1:0]   a,
    input  logic [mips_isa_pkg::imm_w-1:0]    imm,
    input  logic                              imm_signed,
    output logic [mips_isa_pkg::word_w-1:0]   result
);

    logic [mips_isa_pkg::word_w-1:0] imm_ext;

    // ori takes the immediate zero extended
    // the others sign extend it
    assign imm_ext = imm_signed
        ? {{(mips_isa_pkg::word_w - mips_isa_pkg::imm_w){imm[mips_isa_pkg::imm_w-1]}}, imm}
        : {{(mips_isa_pkg::word_w - mips_isa_pkg::imm_w){1'b0}}, imm};

    always_comb begin
        case (op)
            mips_core_pkg::alu_add: begin
                result = a + imm_ext;
            end
            mips_core_pkg::alu_or: begin
                result = a | imm_ext;
            end
            mips_core_pkg::alu_slt: begin
                // both operands compared as two's complement
                result = {{(mips_isa_pkg::word_w - 1){1'b0}},
                          $signed(a) < $signed(imm_ext)};
            end
            default: begin
                result = a + imm_ext;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] rd_addr,
    input  logic                                write,
    input  logic [mips_isa_pkg::word_w-1:0]     write_data,
    output logic [mips_isa_pkg::word_w-1:0]     rs_data,
    output logic [mips_isa_pkg::word_w-1:0]     rt_data
);

    logic [mips_isa_pkg::word_w-1:0] regs [mips_core_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mips_core_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd_addr != '0) begin
            // writes to r0 are dropped
            regs[rd_addr] <= write_data;
        end
    end

    // r0 reads zero whatever the array holds
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

/* rtl/cycle_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module cycle_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  mips_isa_pkg::instr_t  instr,
    // jr target read from the register file is zero
    input  logic                  rs_zero,
    output mips_core_pkg::ctrl_t  ctrl,
    output logic                  halted
);

    mips_core_pkg::state_e state;
    mips_core_pkg::state_e next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mips_core_pkg::st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // idle control word
        ctrl.pc_step     = 1'b0;
        ctrl.pc_jump     = 1'b0;
        ctrl.reg_write   = 1'b0;
        ctrl.reg_src_mem = 1'b0;
        ctrl.imm_signed  = 1'b1;
        ctrl.alu_op      = mips_core_pkg::alu_add;
        ctrl.data_read   = 1'b0;
        ctrl.data_write  = 1'b0;
        next_state       = state;
        case (state)
            mips_core_pkg::st_fetch: begin
                // ir captures the word and pc moves on
                ctrl.pc_step = 1'b1;
                next_state   = mips_core_pkg::st_exec;
            end
            mips_core_pkg::st_exec: begin
                next_state = mips_core_pkg::st_fetch;
                case (instr.opcode)
                    mips_isa_pkg::op_slti: begin
                        ctrl.alu_op    = mips_core_pkg::alu_slt;
                        ctrl.reg_write = 1'b1;
                    end
                    mips_isa_pkg::op_ori: begin
                        ctrl.alu_op     = mips_core_pkg::alu_or;
                        ctrl.imm_signed = 1'b0;
                        ctrl.reg_write  = 1'b1;
                    end
                    mips_isa_pkg::op_addiu: ctrl.reg_write = 1'b1;
                    // address is formed here and used next cycle
                    mips_isa_pkg::op_lw: next_state = mips_core_pkg::st_mem;
                    mips_isa_pkg::op_sw: next_state = mips_core_pkg::st_mem;
                    mips_isa_pkg::op_rtype: begin
                        if (instr.low.r.funct == mips_isa_pkg::fn_jr) begin
                            ctrl.pc_jump = 1'b1;
                            // jump to zero means the program is done
                            if (rs_zero) begin
                                next_state = mips_core_pkg::st_halt;
                            end
                        end
                    end
                    // anything else passes as a nop
                    default: next_state = mips_core_pkg::st_fetch;
                endcase
            end
            mips_core_pkg::st_mem: begin
                next_state = mips_core_pkg::st_fetch;
                if (instr.opcode == mips_isa_pkg::op_lw) begin
                    ctrl.data_read   = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.reg_src_mem = 1'b1;
                end else begin
                    ctrl.data_write = 1'b1;
                end
            end
            default: next_state = mips_core_pkg::st_halt;
        endcase
    end

    assign halted = (state == mips_core_pkg::st_halt);

    // one data access per cycle at most
    bus_exclusive: assert property (@(posedge clk)
        !(ctrl.data_read && ctrl.data_write))
        else $error("data read and write strobes together");

    // the bus stays quiet once the core has stopped
    halt_quiet: assert property (@(posedge clk)
        state == mips_core_pkg::st_halt |-> !ctrl.data_read && !ctrl.data_write)
        else $error("strobe issued while halted");

endmodule

`default_nettype wire

/* rtl/pc_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  mips_core_pkg::ctrl_t ctrl,
    input  logic [31:0]          jump_target,
    output logic [31:0]          pc
);

    // jump wins over step although the fsm never asks for both
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= mips_isa_pkg::reset_vector;
        end else if (ctrl.pc_jump) begin
            pc <= jump_target;
        end else if (ctrl.pc_step) begin
            pc <= pc + 32'd4;
        end
    end

    // every fetch address is a whole word
    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

    // step happens in fetch and jump in exec only
    pc_one_source: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.pc_step && ctrl.pc_jump))
        else $error("pc step and jump in the same cycle");

endmodule

`default_nettype wire

/* rtl/instr_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_rom (
    input  logic [mips_isa_pkg::word_w-1:0] instr_address,
    output logic [mips_isa_pkg::word_w-1:0] instr_readdata
);

    logic [mips_isa_pkg::word_w-1:0] rom [mips_isa_pkg::rom_words];
    logic [mips_isa_pkg::word_w-1:0] offset;
    logic [$clog2(mips_isa_pkg::rom_words)-1:0] word_index;

    // i-type field group
    function automatic logic [31:0] i_type(
        input mips_isa_pkg::opcode_e op,
        input logic [4:0]            rs,
        input logic [4:0]            rt,
        input logic [15:0]           imm
    );
        return {op, rs, rt, imm};
    endfunction

    // r-type field group
    function automatic logic [31:0] r_type(
        input mips_isa_pkg::opcode_e op,
        input logic [4:0]            rs,
        input logic [4:0]            rt,
        input logic [4:0]            rd,
        input logic [4:0]            shamt,
        input mips_isa_pkg::funct_e  funct
    );
        return {op, rs, rt, rd, shamt, funct};
    endfunction

    initial begin
        int ptr;
        // unused words decode as sll r0 which does nothing
        for (ptr = 0; ptr < mips_isa_pkg::rom_words; ptr++) begin
            rom[ptr] = '0;
        end
        ptr = 0;
        // lw ri, 4*(i-2)(r0)
        for (int n = 0; n < mips_core_pkg::test_words; n++) begin
            rom[ptr] = i_type(mips_isa_pkg::op_lw, 5'd0,
                              5'(mips_core_pkg::first_test_reg + n),
                              16'(mips_core_pkg::load_base + 4 * n));
            ptr++;
        end
        // slti ri, ri, 1
        for (int n = 0; n < mips_core_pkg::test_words; n++) begin
            rom[ptr] = i_type(mips_isa_pkg::op_slti,
                              5'(mips_core_pkg::first_test_reg + n),
                              5'(mips_core_pkg::first_test_reg + n), 16'd1);
            ptr++;
        end
        // sw ri, 0x100 + 4*(i-2)(r0)
        for (int n = 0; n < mips_core_pkg::test_words; n++) begin
            rom[ptr] = i_type(mips_isa_pkg::op_sw, 5'd0,
                              5'(mips_core_pkg::first_test_reg + n),
                              16'(mips_core_pkg::store_base + 4 * n));
            ptr++;
        end
        // jr r0 ends the program
        rom[ptr] = r_type(mips_isa_pkg::op_rtype, 5'd0, 5'd0, 5'd0, 5'd0,
                          mips_isa_pkg::fn_jr);
    end

    // word index relative to the reset vector
    assign offset     = instr_address - mips_isa_pkg::reset_vector;
    assign word_index = offset[2 +: $clog2(mips_isa_pkg::rom_words)];

    always_comb begin
        instr_readdata = rom[word_index];
    end

endmodule

`default_nettype wire

/* rtl/mips_core_pkg.sv */
`default_nettype none

package mips_core_pkg;

    // multicycle sequence
    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_halt
    } state_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_or,
        alu_slt
    } alu_op_e;

    // control word from the fsm to the datapath
    typedef struct packed {
        logic    pc_step;
        logic    pc_jump;
        logic    reg_write;
        // write back the load data and not the alu result
        logic    reg_src_mem;
        logic    imm_signed;
        alu_op_e alu_op;
        logic    data_read;
        logic    data_write;
    } ctrl_t;

    localparam int reg_count = 32;

    // layout of the self-test data
    localparam int          test_words     = 30;
    localparam int          first_test_reg = 2;
    localparam logic [31:0] load_base      = 32'h0000_0000;
    localparam logic [31:0] store_base     = 32'h0000_0100;

endpackage

`default_nettype wire

/* rtl/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    // field widths of one instruction word
    localparam int word_w     = 32;
    localparam int opcode_w   = 6;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;
    localparam int funct_w    = 6;
    localparam int imm_w      = 16;

    // instruction memory depth in words
    localparam int rom_words = 4096;
    // first fetch address after reset
    localparam logic [word_w-1:0] reset_vector = 32'hBFC00000;

    // only the opcodes this core executes
    typedef enum logic [opcode_w-1:0] {
        op_rtype = 6'h00,
        op_addiu = 6'h09,
        op_slti  = 6'h0A,
        op_ori   = 6'h0D,
        op_lw    = 6'h23,
        op_sw    = 6'h2B
    } opcode_e;

    // r-type function codes
    typedef enum logic [funct_w-1:0] {
        fn_jr = 6'h08
    } funct_e;

    // lower half as seen by r-type instructions
    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [shamt_w-1:0]    shamt;
        funct_e                funct;
    } rtype_fields_t;

    // same 16 bits hold either the r-type fields or the immediate
    typedef union packed {
        rtype_fields_t    r;
        logic [imm_w-1:0] imm;
    } low_fields_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        low_fields_t           low;
    } instr_t;

endpackage

`default_nettype wire
